// ==== all.f ====
+incdir+source
source/plotter_pkg.sv
source/cmd_fifo.sv
source/coord_file.sv
source/plot_sequencer.sv
source/rect_scanner.sv
source/draw_cmd_builder.sv
source/geometry_plotter.sv
verif/plotter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the geometry plotter testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module plotter_tb -o plotter_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/plotter_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0

// ==== source/cmd_fifo.sv ====
`default_nettype none

`include "plotter_macros.svh"

module cmd_fifo #(
  parameter int DEPTH  = `FIFO_DEPTH,
  parameter int MARGIN = `FIFO_MARGIN
) (
  input  wire                clk,
  input  wire                reset,
  input  wire                wr_en,       // host write strobe
  input  wire  [`CMD_W-1:0]  wr_data,
  input  wire                rd_en,       // pop the head word
  output logic [`CMD_W-1:0]  rd_data,     // head word, show-ahead
  output logic               empty,
  output logic               almost_full
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);
  localparam logic [CW-1:0] AF_CNT   = CW'(DEPTH - MARGIN);

  logic [`CMD_W-1:0] mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [CW-1:0]     count;
  logic              do_wr;
  logic              do_rd;

  assign do_wr       = wr_en && (count != FULL_CNT); // full fifo drops the word
  assign do_rd       = rd_en && !empty;
  assign empty       = (count == '0);
  assign almost_full = (count >= AF_CNT);
  assign rd_data     = mem[rd_ptr];                  // head always visible

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // circular wrap
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // idle or write and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/coord_file.sv ====
`default_nettype none

`include "plotter_macros.svh"

module coord_file import plotter_pkg::*; (
  input  wire       clk,
  input  wire       reset,
  input  wire       wr_x,     // x[wr_sel] <= wr_data
  input  wire       wr_y,     // y[wr_sel] <= wr_data
  input  wire       wr_max,   // limits <= pair at wr_sel
  input  wire       reg_sel_t wr_sel,
  input  wire       coord_t   wr_data,
  input  wire       reg_sel_t rd_sel,
  output coord_t    rd_x,     // pair for address and width commands
  output coord_t    rd_y,
  output coord_t    x0,       // rectangle corners
  output coord_t    y0,
  output coord_t    x1,
  output coord_t    y1,
  output coord_t    max_x,    // clip limits
  output coord_t    max_y
);

  coord_t x_reg [`NUM_COORD];
  coord_t y_reg [`NUM_COORD];

  // **************************************************
  // register writes
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `NUM_COORD; i++) begin
        x_reg[i] <= '0;
        y_reg[i] <= '0;
      end
      max_x <= '0;
      max_y <= '0;
    end else begin
      if (wr_x) begin
        x_reg[wr_sel] <= wr_data;
      end
      if (wr_y) begin
        y_reg[wr_sel] <= wr_data;
      end
      if (wr_max) begin
        max_x <= x_reg[wr_sel]; // limits come from a whole pair
        max_y <= y_reg[wr_sel];
      end
    end
  end

  assign rd_x = x_reg[rd_sel];
  assign rd_y = y_reg[rd_sel];
  assign x0   = x_reg[0];       // start corner
  assign y0   = y_reg[0];
  assign x1   = x_reg[1];       // end corner
  assign y1   = y_reg[1];

endmodule

`default_nettype wire

// ==== source/draw_cmd_builder.sv ====
`default_nettype none

`include "plotter_macros.svh"

module draw_cmd_builder import plotter_pkg::*; (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      advance,   // low while the writer stalls
  input  wire                      emit,
  input  wire draw_func_t          func,
  input  wire [7:0]                color,
  input  wire coord_t              reg_x,
  input  wire coord_t              reg_y,
  input  wire coord_t              pixel_x,
  input  wire coord_t              pixel_y,
  output logic [`DRAW_CMD_W-1:0]   draw_cmd,
  output logic                     draw_cmd_rdy
);

  coord_t word_x;
  coord_t word_y;
  logic   tx;      // a held command waits for the writer

  // coordinate field source per function
  always_comb begin
    case (func)
      DSTMADDR, SRCMADDR, DSTRWDTH, SRCRWDTH: begin
        word_y = reg_y;                              // upper address or width bits
        word_x = reg_x;
      end
      RST_PXWRI_M, RST_PXPASTE_M: begin
        word_y = {color, color[7:4]};                // replicated mask colors
        word_x = {4'h0, color[3:0], color[7:4]};
      end
      default: begin
        word_y = pixel_y;
        word_x = pixel_x;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tx <= 1'b0;
    end else if (advance) begin
      tx <= emit;                                    // one transfer per emit
    end
  end

  always_ff @(posedge clk) begin
    if (advance && emit) begin
      draw_cmd <= {func, color, word_y, word_x};
    end
  end

  assign draw_cmd_rdy = tx && advance;

endmodule

`default_nettype wire

// ==== source/geometry_plotter.sv ====
`default_nettype none

`include "plotter_macros.svh"

module geometry_plotter import plotter_pkg::*; (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     fifo_cmd_ready,  // host write strobe
  input  wire [`CMD_W-1:0]        fifo_cmd_in,
  input  wire                     draw_busy,
  output wire                     load_cmd,
  output wire                     draw_cmd_rdy,
  output wire [`DRAW_CMD_W-1:0]   draw_cmd,
  output wire                     fifo_cmd_busy
);

  wire [`CMD_W-1:0] cmd_word;
  wire              cmd_empty;
  wire              pop;
  wire              advance;
  wire              wr_x;
  wire              wr_y;
  wire              wr_max;
  wire reg_sel_t    wr_sel;
  wire reg_sel_t    rd_sel;
  wire coord_t      wr_data;
  wire coord_t      rd_x;
  wire coord_t      rd_y;
  wire coord_t      x0;
  wire coord_t      y0;
  wire coord_t      x1;
  wire coord_t      y1;
  wire coord_t      max_x;
  wire coord_t      max_y;
  wire              scan_start;
  wire              fill;
  wire              emit;
  wire draw_func_t  func;
  wire [7:0]        color;
  wire coord_t      pixel_x;
  wire coord_t      pixel_y;
  wire              pixel_valid;
  wire              scan_done;

  // **************************************************
  // command path
  // **************************************************
  cmd_fifo #(
    .DEPTH  (`FIFO_DEPTH),
    .MARGIN (`FIFO_MARGIN)
  ) cmd_fifo_i (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (fifo_cmd_ready),
    .wr_data     (fifo_cmd_in),
    .rd_en       (pop),
    .rd_data     (cmd_word),
    .empty       (cmd_empty),
    .almost_full (fifo_cmd_busy)
  );

  plot_sequencer plot_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .draw_busy   (draw_busy),
    .cmd_empty   (cmd_empty),
    .cmd_word    (cmd_word),
    .pixel_valid (pixel_valid),
    .scan_done   (scan_done),
    .pop         (pop),
    .load_cmd    (load_cmd),
    .advance     (advance),
    .wr_x        (wr_x),
    .wr_y        (wr_y),
    .wr_max      (wr_max),
    .wr_sel      (wr_sel),
    .rd_sel      (rd_sel),
    .wr_data     (wr_data),
    .scan_start  (scan_start),
    .fill        (fill),
    .emit        (emit),
    .func        (func),
    .color       (color)
  );

  coord_file coord_file_i (
    .clk     (clk),
    .reset   (reset),
    .wr_x    (wr_x),
    .wr_y    (wr_y),
    .wr_max  (wr_max),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .rd_sel  (rd_sel),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .x0      (x0),
    .y0      (y0),
    .x1      (x1),
    .y1      (y1),
    .max_x   (max_x),
    .max_y   (max_y)
  );

  // **************************************************
  // shape and output stage
  // **************************************************
  rect_scanner rect_scanner_i (
    .clk         (clk),
    .reset       (reset),
    .scan_start  (scan_start),
    .step        (advance),
    .fill        (fill),
    .x0          (x0),
    .y0          (y0),
    .x1          (x1),
    .y1          (y1),
    .max_x       (max_x),
    .max_y       (max_y),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_valid (pixel_valid),
    .scan_done   (scan_done)
  );

  draw_cmd_builder draw_cmd_builder_i (
    .clk          (clk),
    .reset        (reset),
    .advance      (advance),
    .emit         (emit),
    .func         (func),
    .color        (color),
    .reg_x        (rd_x),
    .reg_y        (rd_y),
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .draw_cmd     (draw_cmd),
    .draw_cmd_rdy (draw_cmd_rdy)
  );

endmodule

`default_nettype wire

// ==== source/plot_sequencer.sv ====
`default_nettype none

`include "plotter_macros.svh"

module plot_sequencer import plotter_pkg::*; (
  input  wire               clk,
  input  wire               reset,
  input  wire               draw_busy,   // pixel writer stall
  input  wire               cmd_empty,
  input  wire [`CMD_W-1:0]  cmd_word,    // fifo head
  input  wire               pixel_valid,
  input  wire               scan_done,
  output logic              pop,
  output logic              load_cmd,
  output logic              advance,     // pipeline may move this cycle
  output logic              wr_x,
  output logic              wr_y,
  output logic              wr_max,
  output reg_sel_t          wr_sel,
  output reg_sel_t          rd_sel,
  output coord_t            wr_data,
  output logic              scan_start,
  output logic              fill,
  output logic              emit,        // builder loads a command
  output draw_func_t        func,
  output logic [7:0]        color
);

  plot_state_t state;
  cmd_kind_t   kind;
  logic [7:0]  opcode;
  logic [7:0]  data8;
  logic        rect_cmd;
  logic [7:0]  color_q;  // pen color of the running shape
  logic        paste_q;  // paste bit of the running shape

  assign opcode = cmd_word[15:8];
  assign data8  = cmd_word[7:0];

  // **************************************************
  // opcode decode
  // **************************************************
  always_comb begin
    casez (opcode)
      8'b10??????:                  kind = SET_X;
      8'b11??????:                  kind = SET_Y;
      8'b011111??:                  kind = DST_ADDR;
      8'b011110??:                  kind = SRC_ADDR;
      8'd115, 8'd113:               kind = DST_WIDTH;
      8'd114, 8'd112:               kind = SRC_WIDTH;
      8'd95, 8'd94, 8'd93, 8'd92:   kind = SET_MAX;
      8'd91, 8'd90:                 kind = RST_COLL;
      8'b000?????:                  kind = DRAW_SHAPE;
      default:                      kind = IGNORE;     // includes 116..119
    endcase
  end

  assign advance  = !draw_busy;
  assign load_cmd = (state == IDLE);
  assign pop      = load_cmd && advance && !cmd_empty;
  assign rect_cmd = (kind == DRAW_SHAPE) && (opcode[2:0] == 3'd2); // only shape 2 draws

  assign wr_x    = pop && (kind == SET_X);
  assign wr_y    = pop && (kind == SET_Y);
  assign wr_max  = pop && (kind == SET_MAX);
  assign wr_sel  = (kind == SET_MAX) ? ~opcode[1:0] : opcode[5:4]; // 95 picks pair 0
  assign wr_data = cmd_word[`COORD_W-1:0];
  // addresses index by opcode, widths use pair 2 (115/114) or 3 (113/112)
  assign rd_sel  = (kind == DST_ADDR || kind == SRC_ADDR) ? opcode[1:0] : {1'b1, ~opcode[1]};

  assign scan_start = pop && rect_cmd;
  assign fill       = opcode[3];

  // **************************************************
  // command steering
  // **************************************************
  always_comb begin
    func  = NOP;
    emit  = 1'b0;
    color = data8;
    if (state == RECT_RUN) begin
      func  = paste_q ? PXPASTE : PXWRI;
      emit  = pixel_valid;           // one command per drawn pixel
      color = color_q;
    end else if (pop) begin
      emit = 1'b1;
      case (kind)
        DST_ADDR:  func = DSTMADDR;
        SRC_ADDR:  func = SRCMADDR;
        DST_WIDTH: func = DSTRWDTH;
        SRC_WIDTH: func = SRCRWDTH;
        RST_COLL:  func = opcode[0] ? RST_PXWRI_M : RST_PXPASTE_M;
        default:   emit = 1'b0;      // register writes, draws, ignored
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else if (scan_start) begin
      state <= RECT_RUN;
    end else if (state == RECT_RUN && scan_done) begin
      state <= IDLE;                 // scanner finished the last row
    end
  end

  always_ff @(posedge clk) begin
    if (scan_start) begin
      color_q <= data8;
      paste_q <= opcode[4];
    end
  end

endmodule

`default_nettype wire

// ==== source/plotter_macros.svh ====
`ifndef PLOTTER_MACROS_SVH
`define PLOTTER_MACROS_SVH

// **************************************************
// data path widths
// **************************************************
`define COORD_W     12   // x/y coordinate bits
`define CMD_W       16   // host command word, opcode in the top byte
`define DRAW_CMD_W  36   // pixel writer command word

// **************************************************
// command fifo sizing
// **************************************************
`define FIFO_DEPTH  512  // command entries
`define FIFO_MARGIN 32   // free slots left when fifo_cmd_busy rises

// **************************************************
// coordinate register file
// **************************************************
`define NUM_COORD   4    // x/y register pairs

`endif

// ==== source/plotter_pkg.sv ====
`default_nettype none

`include "plotter_macros.svh"

package plotter_pkg;

  typedef logic [`COORD_W-1:0]          coord_t;    // unsigned screen coordinate
  typedef logic [$clog2(`NUM_COORD)-1:0] reg_sel_t; // x/y register index

  // function code in bits 35:32 of the pixel writer command
  typedef enum logic [3:0] {
    NOP           = 4'd0,
    PXWRI         = 4'd1,  // write pixel
    PXWRI_M       = 4'd2,  // write pixel, masked
    PXPASTE       = 4'd3,  // write from read pixel
    PXPASTE_M     = 4'd4,  // write from read pixel, masked
    PXCOPY        = 4'd6,  // read source pixel
    SETARGB       = 4'd7,  // true color pen
    RST_PXWRI_M   = 4'd10, // clear write collision counter
    RST_PXPASTE_M = 4'd11, // clear paste collision counter
    DSTRWDTH      = 4'd12, // destination raster width
    SRCRWDTH      = 4'd13, // source raster width
    DSTMADDR      = 4'd14, // destination base address
    SRCMADDR      = 4'd15  // source base address
  } draw_func_t;

  // opcode classes seen by the sequencer
  typedef enum logic [3:0] {
    SET_X, SET_Y, DST_ADDR, SRC_ADDR, DST_WIDTH, SRC_WIDTH,
    SET_MAX, RST_COLL, DRAW_SHAPE, IGNORE
  } cmd_kind_t;

  typedef enum logic {
    IDLE,     // popping commands
    RECT_RUN  // rectangle scan in progress
  } plot_state_t;

endpackage

`default_nettype wire

// ==== source/rect_scanner.sv ====
`default_nettype none

`include "plotter_macros.svh"

module rect_scanner import plotter_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        scan_start,  // latch corners and begin
  input  wire        step,        // move one position
  input  wire        fill,
  input  wire        coord_t x0,
  input  wire        coord_t y0,
  input  wire        coord_t x1,
  input  wire        coord_t y1,
  input  wire        coord_t max_x,
  input  wire        coord_t max_y,
  output coord_t     pixel_x,
  output coord_t     pixel_y,
  output logic       pixel_valid,
  output logic       scan_done
);

  coord_t x0_q;
  coord_t x1_q;
  coord_t y0_q;
  coord_t y1_q;
  logic   fill_q;
  coord_t x_dir;     // +1, -1 or 0 in two's complement
  coord_t y_dir;
  logic   active;
  logic   row_end;   // row drawn, next step changes row
  logic   edge_row;
  logic   last_row;
  logic   in_clip;

  function automatic coord_t dir_of(coord_t from, coord_t to);
    if (to > from) begin
      return coord_t'(1);
    end else if (to < from) begin
      return '1;
    end
    return '0;
  endfunction

  assign edge_row    = (pixel_y == y0_q) || (pixel_y == y1_q); // top and bottom lines
  assign last_row    = (pixel_y == y1_q);
  assign in_clip     = (pixel_x <= max_x) && (pixel_y <= max_y);
  assign pixel_valid = step && active && !row_end && in_clip;
  assign scan_done   = step && active && row_end && last_row;

  always_ff @(posedge clk) begin
    if (scan_start) begin
      x0_q   <= x0;
      x1_q   <= x1;
      y0_q   <= y0;
      y1_q   <= y1;
      fill_q <= fill;
    end
  end

  // **************************************************
  // position walk
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active  <= 1'b0;
      row_end <= 1'b0;
      pixel_x <= '0;
      pixel_y <= '0;
      x_dir   <= '0;
      y_dir   <= '0;
    end else if (scan_start) begin
      active  <= 1'b1;
      row_end <= 1'b0;
      pixel_x <= x0;
      pixel_y <= y0;
      x_dir   <= dir_of(x0, x1);
      y_dir   <= dir_of(y0, y1);
    end else if (step && active) begin
      if (row_end) begin
        row_end <= 1'b0;                 // empty cycle between rows
        if (last_row) begin
          active <= 1'b0;
        end else begin
          pixel_y <= pixel_y + y_dir;
          pixel_x <= x0_q;
        end
      end else if (pixel_x == x1_q) begin
        row_end <= 1'b1;                 // far edge reached
      end else if (fill_q || edge_row) begin
        pixel_x <= pixel_x + x_dir;
      end else begin
        pixel_x <= x1_q;                 // outline middle row, skip to far edge
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/plotter_tb.sv ====
`default_nettype none

`include "plotter_macros.svh"

module plotter_tb import plotter_pkg::*; ();

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    fifo_cmd_ready;
  logic [`CMD_W-1:0]       fifo_cmd_in;
  logic                    draw_busy;
  wire                     load_cmd;
  wire                     draw_cmd_rdy;
  wire  [`DRAW_CMD_W-1:0]  draw_cmd;
  wire                     fifo_cmd_busy;

  logic [`DRAW_CMD_W-1:0]  exp_q [$];          // modeled output words, in order
  logic [`DRAW_CMD_W-1:0]  exp_word;
  logic [15:0]             lfsr_state = 16'd99;
  int                      sh_x [4];           // shadow of the x/y registers
  int                      sh_y [4];
  int                      mx = 0;             // shadow clip limits
  int                      my = 0;
  int                      busy_mode = 0;      // 0 free, 1 random stall, 2 held
  int                      n_cmds = 0;
  int                      n_words = 0;
  int                      n_rows = 0;
  int                      cycles = 0;

  geometry_plotter geometry_plotter_i (
    .clk            (clk),
    .reset          (reset),
    .fifo_cmd_ready (fifo_cmd_ready),
    .fifo_cmd_in    (fifo_cmd_in),
    .draw_busy      (draw_busy),
    .load_cmd       (load_cmd),
    .draw_cmd_rdy   (draw_cmd_rdy),
    .draw_cmd       (draw_cmd),
    .fifo_cmd_busy  (fifo_cmd_busy)
  );

  always #4 clk = ~clk;  // 8 unit period

  // **************************************************
  // random source and reference model
  // **************************************************
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);             // one step per bit
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  function automatic int step_dir(input int from, input int to);
    return (to > from) ? 1 : ((to < from) ? -1 : 0);
  endfunction

  function automatic void expect_word(input draw_func_t f, input int c, input int y,
                                      input int x);
    exp_q.push_back({f, 8'(c), coord_t'(y), coord_t'(x)});
    n_words++;
  endfunction

  function automatic void plot_pixel(input draw_func_t f, input int c, input int x, input int y);
    if (x <= mx && y <= my) begin
      expect_word(f, c, y, x);                        // clipped pixels vanish
    end
  endfunction

  function automatic void model_rect(input bit fill, input bit paste, input int c);
    draw_func_t f;
    int         dx;
    int         dy;
    int         x;
    int         y;
    bit         done;
    f    = paste ? PXPASTE : PXWRI;
    dx   = step_dir(sh_x[0], sh_x[1]);
    dy   = step_dir(sh_y[0], sh_y[1]);
    y    = sh_y[0];
    done = 1'b0;
    while (!done) begin
      if (fill || y == sh_y[0] || y == sh_y[1]) begin
        x = sh_x[0];                                  // whole row
        plot_pixel(f, c, x, y);
        while (x != sh_x[1]) begin
          x = x + dx;
          plot_pixel(f, c, x, y);
        end
      end else begin
        plot_pixel(f, c, sh_x[0], y);                 // outline sides only
        if (sh_x[1] != sh_x[0]) begin
          plot_pixel(f, c, sh_x[1], y);
        end
      end
      n_rows++;
      done = (y == sh_y[1]);
      y    = y + dy;
    end
  endfunction

  function automatic void model_cmd(input logic [15:0] w);
    int         op;
    int         d;
    logic [1:0] sel;
    op = int'(w[15:8]);
    d  = int'(w[7:0]);
    if (op >= 192) begin
      sh_y[w[13:12]] = int'(w[11:0]);
    end else if (op >= 128) begin
      sh_x[w[13:12]] = int'(w[11:0]);
    end else if (op >= 120) begin
      sel = w[9:8];
      expect_word((op >= 124) ? DSTMADDR : SRCMADDR, d, sh_y[sel], sh_x[sel]);
    end else if (op >= 112 && op <= 115) begin
      sel = (op == 115 || op == 114) ? 2'd2 : 2'd3;
      expect_word((op % 2 == 1) ? DSTRWDTH : SRCRWDTH, d, sh_y[sel], sh_x[sel]);
    end else if (op >= 92 && op <= 95) begin
      sel = 2'(95 - op);                              // 95 is pair 0
      mx  = sh_x[sel];
      my  = sh_y[sel];
    end else if (op == 91 || op == 90) begin
      expect_word((op == 91) ? RST_PXWRI_M : RST_PXPASTE_M, d,
                  d * 16 + d / 16, (d % 16) * 16 + d / 16);
    end else if (op < 32 && w[10:8] == 3'd2) begin
      model_rect(w[11], w[12], d);                    // only shape 2 draws
    end
  endfunction

  function automatic logic [15:0] random_cmd();
    logic [15:0] r;
    int          kind;
    r    = 16'(rand_bits(16));
    kind = rand_bits(3);
    case (kind)
      0, 1, 2: return {1'b1, r[6], r[5:4], 9'd0, r[2:0]};  // small coordinate
      3:       return {6'b011111, r[9:8], r[7:0]};         // dst address
      4:       return {6'b011101, r[9:8], r[7:0]};         // 116..119, ignored
      5:       return {6'b010111, r[9:8], r[7:0]};         // limits
      6:       return {6'b010110, r[9:8], r[7:0]};         // 88..91
      default: return {3'b000, r[12:8], r[7:0]};           // any shape
    endcase
  endfunction

  // **************************************************
  // checks
  // **************************************************
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_draw_cmd(input draw_func_t got_f, input logic [7:0] got_c,
                                input coord_t got_y, input coord_t got_x,
                                input draw_func_t exp_f, input logic [7:0] exp_c,
                                input coord_t exp_y, input coord_t exp_x);
    if (got_f !== exp_f || got_c !== exp_c || got_y !== exp_y || got_x !== exp_x) begin
      stop_run($sformatf("Fail at %0t: draw_cmd %s c=%h y=%0d x=%0d, exp %s c=%h y=%0d x=%0d",
                         $time, got_f.name(), got_c, got_y, got_x,
                         exp_f.name(), exp_c, exp_y, exp_x));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    if (!reset && draw_cmd_rdy) begin                 // one transfer per edge
      if (exp_q.size() == 0) begin
        stop_run($sformatf("unexpected command %h came out at time %0t", draw_cmd, $time));
      end else begin
        exp_word = exp_q.pop_front();
        check_draw_cmd(draw_func_t'(draw_cmd[35:32]), draw_cmd[31:24],
                       draw_cmd[23:12], draw_cmd[11:0],
                       draw_func_t'(exp_word[35:32]), exp_word[31:24],
                       exp_word[23:12], exp_word[11:0]);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > 8 * (n_cmds + n_words + n_rows) + 2000) begin
      stop_run($sformatf("timeout, the run went past %0d cycles", cycles));
    end
  end

  // **************************************************
  // stimulus
  // **************************************************
  task automatic drive_busy();
    if (busy_mode == 2) begin
      draw_busy = 1'b1;
    end else if (busy_mode == 1) begin
      draw_busy = (rand_bits(2) == 3);                // stall about one cycle in four
    end else begin
      draw_busy = 1'b0;
    end
  endtask

  task automatic send_cmd(input logic [15:0] w);
    @(negedge clk);
    drive_busy();
    fifo_cmd_ready = 1'b1;
    fifo_cmd_in    = w;
    model_cmd(w);
    n_cmds++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    drive_busy();
    fifo_cmd_ready = 1'b0;
  endtask

  task automatic wait_drain();
    int limit;
    int waited;
    send_cmd({6'b011111, 2'(rand_bits(2)), 8'(rand_bits(8))});  // marks the fifo tail
    limit  = 16 * exp_q.size() + 4000;
    waited = 0;
    while ((exp_q.size() != 0 || !load_cmd) && waited < limit) begin
      idle_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      stop_run($sformatf("missing commands, %0d expected words never came out", exp_q.size()));
    end
  endtask

  task automatic set_reg(input bit is_y, input int idx, input int val);
    send_cmd({is_y ? 2'b11 : 2'b10, 2'(idx), 12'(val)});
  endtask

  task automatic draw(input bit fill, input bit paste, input int shape, input int color);
    send_cmd({3'b000, paste, fill, 3'(shape), 8'(color)});
  endtask

  task automatic rect_case(input int xa, input int ya, input int xb, input int yb,
                           input bit fill);
    logic [8:0] r;
    set_reg(1'b0, 0, xa);
    set_reg(1'b1, 0, ya);
    set_reg(1'b0, 1, xb);
    set_reg(1'b1, 1, yb);
    r = 9'(rand_bits(9));
    draw(fill, r[8], 2, int'(r[7:0]));                // random paste bit and color
  endtask

  initial begin
    int         lo_x;
    int         hi_x;
    int         lo_y;
    int         hi_y;
    logic [9:0] r;
    reset          = 1'b1;
    fifo_cmd_ready = 1'b0;
    fifo_cmd_in    = '0;
    draw_busy      = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("load_cmd", load_cmd, 1'b1);
    check_flag("draw_cmd_rdy", draw_cmd_rdy, 1'b0);
    check_flag("fifo_cmd_busy", fifo_cmd_busy, 1'b0);

    busy_mode = 1;
    for (int i = 0; i < 4; i++) begin
      set_reg(1'b0, i, rand_bits(12));
      set_reg(1'b1, i, rand_bits(12));
    end
    for (int i = 0; i < 4; i++) begin
      send_cmd({6'b011111, 2'(i), 8'(rand_bits(8))});
      send_cmd({6'b011110, 2'(i), 8'(rand_bits(8))});
    end
    for (int i = 112; i <= 119; i++) begin
      send_cmd({8'(i), 8'(rand_bits(8))});            // widths, then unused codes
    end
    for (int s = 0; s < 8; s++) begin
      r = 10'(rand_bits(10));
      if (s != 2) begin
        draw(r[9], r[8], s, int'(r[7:0]));            // shapes without a generator
      end
    end
    send_cmd({8'd100, 8'(rand_bits(8))});
    send_cmd({8'd40, 8'(rand_bits(8))});
    send_cmd({8'd89, 8'(rand_bits(8))});
    wait_drain();

    send_cmd({8'd91, 8'(rand_bits(8))});              // collision resets
    send_cmd({8'd90, 8'(rand_bits(8))});
    for (int i = 92; i <= 95; i++) begin
      send_cmd({8'(i), 8'(rand_bits(8))});
    end
    wait_drain();

    set_reg(1'b0, 2, 4095);                           // pair 2 leaves the screen open
    set_reg(1'b1, 2, 4095);
    set_reg(1'b0, 3, 10);                             // pair 3 cuts some corners off
    set_reg(1'b1, 3, 12);
    for (int lim = 0; lim < 2; lim++) begin
      send_cmd({(lim == 0) ? 8'd93 : 8'd92, 8'(rand_bits(8))});
      for (int k = 0; k < 4; k++) begin
        for (int f = 0; f < 2; f++) begin
          lo_x = 4 + rand_bits(3);
          hi_x = lo_x + 1 + rand_bits(3);
          lo_y = 4 + rand_bits(3);
          hi_y = lo_y + 1 + rand_bits(3);
          rect_case((k % 2 == 1) ? hi_x : lo_x, (k / 2 == 1) ? hi_y : lo_y,
                    (k % 2 == 1) ? lo_x : hi_x, (k / 2 == 1) ? lo_y : hi_y, f == 1);
        end
      end
    end
    for (int f = 0; f < 2; f++) begin
      rect_case(3, 5, 9, 5, f == 1);                  // single rows
      rect_case(9, 5, 3, 5, f == 1);
      rect_case(6, 2, 6, 8, f == 1);                  // single columns
      rect_case(6, 8, 6, 2, f == 1);
    end
    rect_case(4, 4, 4, 4, 1'b0);
    rect_case(12, 9, 2, 3, 1'b1);
    send_cmd({8'd94, 8'(rand_bits(8))});              // limits from corner 1
    draw(1'b1, 1'b0, 2, rand_bits(8));
    send_cmd({8'd95, 8'(rand_bits(8))});              // limits from corner 0
    draw(1'b0, 1'b1, 2, rand_bits(8));
    wait_drain();

    // fifo fill with the writer stalled
    busy_mode = 2;
    for (int i = 0; i < `FIFO_DEPTH - `FIFO_MARGIN - 1; i++) begin
      send_cmd(random_cmd());
    end
    idle_cycle();
    check_flag("fifo_cmd_busy", fifo_cmd_busy, 1'b0);
    check_flag("draw_cmd_rdy", draw_cmd_rdy, 1'b0);
    send_cmd(random_cmd());
    idle_cycle();
    check_flag("fifo_cmd_busy", fifo_cmd_busy, 1'b1);
    busy_mode = 1;
    wait_drain();

    busy_mode = 0;
    repeat (50) idle_cycle();                         // catch stray outputs
    if (exp_q.size() != 0) begin
      stop_run($sformatf("missing commands, %0d expected words left at the end", exp_q.size()));
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
